/* source/board_top.sv */
`timescale 1ns/1ps

module board_top #(
    parameter int BAUD_DIV = 868,
    parameter int SPI_DIV  = 4,
    parameter int SCAN_DIV = 50000
) (
    input  logic        clk,
    input  logic        reset_i,
    // GPIO
    input  logic [7:0]  switch_i,
    output logic [15:0] led_o,
    output logic [7:0]  seg_sel_o,
    output logic [7:0]  seg_bit_o,
    // SPI
    output logic        spi_sck_o,
    output logic        spi_ss_o,
    output logic        spi_mosi_o,
    input  logic        spi_miso_i,
    // UART
    input  logic        uart_rxd_i,
    output logic        uart_txd_o
);

    logic           rx_valid;
    soc_pkg::byte_t rx_data;
    logic           tx_start;
    logic           tx_busy;
    soc_pkg::byte_t tx_data;
    logic           led_we_lo;
    logic           led_we_hi;
    logic           seg_we;
    soc_pkg::byte_t wr_data;
    soc_pkg::byte_t switch_sync;
    logic           spi_start;
    logic           spi_done;
    soc_pkg::byte_t spi_tx;
    soc_pkg::byte_t spi_rx;

    uart_rx #(.BAUD_DIV(BAUD_DIV)) u_uart_rx (
        .clk(clk), .reset_i(reset_i), .rxd_i(uart_rxd_i),
        .rx_valid_o(rx_valid), .rx_data_o(rx_data)
    );

    uart_tx #(.BAUD_DIV(BAUD_DIV)) u_uart_tx (
        .clk(clk), .reset_i(reset_i), .tx_start_i(tx_start), .tx_data_i(tx_data),
        .txd_o(uart_txd_o), .tx_busy_o(tx_busy)
    );

    cmd_bridge u_cmd_bridge (
        .clk(clk), .reset_i(reset_i),
        .rx_valid_i(rx_valid), .rx_data_i(rx_data),
        .tx_start_o(tx_start), .tx_data_o(tx_data), .tx_busy_i(tx_busy),
        .led_we_lo_o(led_we_lo), .led_we_hi_o(led_we_hi), .seg_we_o(seg_we),
        .wr_data_o(wr_data), .switch_i(switch_sync),
        .spi_start_o(spi_start), .spi_tx_o(spi_tx),
        .spi_done_i(spi_done), .spi_rx_i(spi_rx)
    );

    gpio_ctrl #(.SCAN_DIV(SCAN_DIV)) u_gpio_ctrl (
        .clk(clk), .reset_i(reset_i),
        .led_we_lo_i(led_we_lo), .led_we_hi_i(led_we_hi), .seg_we_i(seg_we),
        .wr_data_i(wr_data), .switch_i(switch_i), .switch_o(switch_sync),
        .led_o(led_o), .seg_sel_o(seg_sel_o), .seg_bit_o(seg_bit_o)
    );

    spi_master #(.SPI_DIV(SPI_DIV)) u_spi_master (
        .clk(clk), .reset_i(reset_i),
        .spi_start_i(spi_start), .spi_tx_i(spi_tx),
        .spi_done_o(spi_done), .spi_rx_o(spi_rx),
        .spi_sck_o(spi_sck_o), .spi_ss_o(spi_ss_o),
        .spi_mosi_o(spi_mosi_o), .spi_miso_i(spi_miso_i)
    );

endmodule

/* source/cmd_bridge.sv */
`timescale 1ns/1ps

module cmd_bridge (
    input  logic              clk,
    input  logic              reset_i,
    // UART receive side
    input  logic              rx_valid_i,
    input  soc_pkg::byte_t    rx_data_i,
    // UART transmit side
    output logic              tx_start_o,
    output soc_pkg::byte_t    tx_data_o,
    input  logic              tx_busy_i,
    // GPIO writes
    output logic              led_we_lo_o,
    output logic              led_we_hi_o,
    output logic              seg_we_o,
    output soc_pkg::byte_t    wr_data_o,
    input  soc_pkg::byte_t    switch_i,
    // SPI
    output logic              spi_start_o,
    output soc_pkg::byte_t    spi_tx_o,
    input  logic              spi_done_i,
    input  soc_pkg::byte_t    spi_rx_i
);

    soc_pkg::bridge_state_e state_q;
    soc_pkg::opcode_e       opcode_q;
    soc_pkg::byte_t         data_q;
    soc_pkg::byte_t         reply_q;
    logic                   exec;

    assign exec = (state_q == soc_pkg::ST_EXEC);

    // Strobes are decoded from the EXEC cycle
    assign led_we_lo_o = exec && (opcode_q == soc_pkg::OP_LED_LO);
    assign led_we_hi_o = exec && (opcode_q == soc_pkg::OP_LED_HI);
    assign seg_we_o    = exec && (opcode_q == soc_pkg::OP_SEG);
    assign spi_start_o = exec && (opcode_q == soc_pkg::OP_SPI);
    assign wr_data_o   = data_q;
    assign spi_tx_o    = data_q;

    assign tx_start_o = (state_q == soc_pkg::ST_REPLY) && !tx_busy_i;
    assign tx_data_o  = reply_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= soc_pkg::ST_OPCODE;
        end else begin
            case (state_q)
                soc_pkg::ST_OPCODE: begin
                    if (rx_valid_i) begin
                        state_q <= soc_pkg::ST_DATA;
                    end
                end
                soc_pkg::ST_DATA: begin
                    if (rx_valid_i) begin
                        state_q <= soc_pkg::ST_EXEC;
                    end
                end
                soc_pkg::ST_EXEC: begin
                    if (opcode_q == soc_pkg::OP_SPI) begin
                        state_q <= soc_pkg::ST_SPI_WAIT;
                    end else begin
                        state_q <= soc_pkg::ST_REPLY;
                    end
                end
                soc_pkg::ST_SPI_WAIT: begin
                    if (spi_done_i) begin
                        state_q <= soc_pkg::ST_REPLY;
                    end
                end
                default: begin
                    // Bytes from the host are dropped until the reply goes out
                    if (tx_start_o) begin
                        state_q <= soc_pkg::ST_OPCODE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == soc_pkg::ST_OPCODE && rx_valid_i) begin
            opcode_q <= soc_pkg::opcode_e'(rx_data_i);
        end
        if (state_q == soc_pkg::ST_DATA && rx_valid_i) begin
            data_q <= rx_data_i;
        end
        if (exec) begin
            case (opcode_q)
                soc_pkg::OP_LED_LO,
                soc_pkg::OP_LED_HI,
                soc_pkg::OP_SEG:    reply_q <= data_q;
                soc_pkg::OP_SWITCH: reply_q <= switch_i;
                soc_pkg::OP_SPI:    reply_q <= reply_q;
                default:            reply_q <= soc_pkg::REPLY_BAD;
            endcase
        end
        if (state_q == soc_pkg::ST_SPI_WAIT && spi_done_i) begin
            reply_q <= spi_rx_i;
        end
    end

endmodule

/* source/gpio_ctrl.sv */
`timescale 1ns/1ps

module gpio_ctrl #(
    parameter int SCAN_DIV = 50000
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              led_we_lo_i,
    input  logic              led_we_hi_i,
    input  logic              seg_we_i,
    input  soc_pkg::byte_t    wr_data_i,
    input  soc_pkg::byte_t    switch_i,
    output soc_pkg::byte_t    switch_o,
    output logic [15:0]       led_o,
    output logic [7:0]        seg_sel_o,
    output logic [7:0]        seg_bit_o
);

    localparam int SCW = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    soc_pkg::byte_t  seg_q;
    soc_pkg::byte_t  sw_meta;
    logic [SCW-1:0]  scan_cnt_q;
    logic            digit_q;
    logic [3:0]      nibble;

    // Segments gfedcba, active high
    function automatic logic [6:0] hex_font(input logic [3:0] val);
        case (val)
            4'h0: hex_font = 7'h3F;
            4'h1: hex_font = 7'h06;
            4'h2: hex_font = 7'h5B;
            4'h3: hex_font = 7'h4F;
            4'h4: hex_font = 7'h66;
            4'h5: hex_font = 7'h6D;
            4'h6: hex_font = 7'h7D;
            4'h7: hex_font = 7'h07;
            4'h8: hex_font = 7'h7F;
            4'h9: hex_font = 7'h6F;
            4'hA: hex_font = 7'h77;
            4'hB: hex_font = 7'h7C;
            4'hC: hex_font = 7'h39;
            4'hD: hex_font = 7'h5E;
            4'hE: hex_font = 7'h79;
            default: hex_font = 7'h71;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        sw_meta  <= switch_i;
        switch_o <= sw_meta;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            led_o <= '0;
            seg_q <= '0;
        end else begin
            if (led_we_lo_i) led_o[7:0] <= wr_data_i;
            if (led_we_hi_i) led_o[15:8] <= wr_data_i;
            if (seg_we_i) seg_q <= wr_data_i;
        end
    end

    // Two-digit scan with nothing lit until the first step
    always_ff @(posedge clk) begin
        if (reset_i) begin
            scan_cnt_q <= '0;
            digit_q    <= 1'b0;
            seg_sel_o  <= 8'hFF;
        end else if (scan_cnt_q == SCW'(SCAN_DIV - 1)) begin
            scan_cnt_q <= '0;
            digit_q    <= ~digit_q;
            seg_sel_o  <= digit_q ? 8'hFD : 8'hFE;
        end else begin
            scan_cnt_q <= scan_cnt_q + 1'b1;
        end
    end

    assign nibble    = seg_sel_o[1] ? seg_q[3:0] : seg_q[7:4];
    // Decimal point stays dark
    assign seg_bit_o = {1'b1, ~hex_font(nibble)};

endmodule

/* source/soc_pkg.sv */
package soc_pkg;

    // One data byte on every internal path
    typedef logic [7:0] byte_t;

    // Host command opcodes
    typedef enum logic [7:0] {
        OP_LED_LO = 8'h01,
        OP_LED_HI = 8'h02,
        OP_SEG    = 8'h03,
        OP_SWITCH = 8'h04,
        OP_SPI    = 8'h05
    } opcode_e;

    // Command bridge FSM
    typedef enum logic [2:0] {
        ST_OPCODE,
        ST_DATA,
        ST_EXEC,
        ST_SPI_WAIT,
        ST_REPLY
    } bridge_state_e;

    // Reply for an unknown opcode
    parameter byte_t REPLY_BAD = 8'hEE;

endpackage

/* source/spi_master.sv */
`timescale 1ns/1ps

module spi_master #(
    parameter int SPI_DIV = 4
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              spi_start_i,
    input  soc_pkg::byte_t    spi_tx_i,
    output logic              spi_done_o,
    output soc_pkg::byte_t    spi_rx_o,
    output logic              spi_sck_o,
    output logic              spi_ss_o,
    output logic              spi_mosi_o,
    input  logic              spi_miso_i
);

    localparam int DW = (SPI_DIV > 2) ? $clog2(SPI_DIV) : 2;

    logic           busy_q;
    logic [DW-1:0]  div_q;
    logic [3:0]     bit_q;
    soc_pkg::byte_t tx_sh;
    logic           half_end;

    assign half_end = busy_q && (div_q == DW'(SPI_DIV - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q     <= 1'b0;
            div_q      <= '0;
            bit_q      <= '0;
            spi_sck_o  <= 1'b0;
            spi_ss_o   <= 1'b1;
            spi_mosi_o <= 1'b0;
            spi_done_o <= 1'b0;
        end else begin
            spi_done_o <= 1'b0;
            if (!busy_q) begin
                // Start is ignored while busy
                if (spi_start_i) begin
                    busy_q     <= 1'b1;
                    div_q      <= '0;
                    bit_q      <= '0;
                    spi_ss_o   <= 1'b0;
                    spi_mosi_o <= spi_tx_i[7];
                end
            end else if (half_end) begin
                div_q <= '0;
                if (spi_sck_o) begin
                    // Falling edge shifts out the next bit
                    spi_sck_o  <= 1'b0;
                    bit_q      <= bit_q + 1'b1;
                    spi_mosi_o <= tx_sh[6];
                end else if (bit_q != 4'd8) begin
                    spi_sck_o <= 1'b1;
                end else begin
                    busy_q     <= 1'b0;
                    spi_ss_o   <= 1'b1;
                    spi_mosi_o <= 1'b0;
                    spi_done_o <= 1'b1;
                end
            end else begin
                div_q <= div_q + 1'b1;
            end
        end
    end

    // Shift registers
    always_ff @(posedge clk) begin
        if (!busy_q && spi_start_i) begin
            tx_sh <= spi_tx_i;
        end else if (half_end && spi_sck_o) begin
            tx_sh <= {tx_sh[6:0], 1'b0};
        end
        if (half_end && !spi_sck_o && bit_q != 4'd8) begin
            spi_rx_o <= {spi_rx_o[6:0], spi_miso_i};
        end
    end

endmodule

/* source/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx #(
    parameter int BAUD_DIV = 868
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              rxd_i,
    output logic              rx_valid_o,
    output soc_pkg::byte_t    rx_data_o
);

    localparam int CW = (BAUD_DIV > 2) ? $clog2(BAUD_DIV) : 2;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e     state_q;
    logic [CW-1:0] cnt_q;
    logic [2:0]    bit_q;
    logic          rxd_meta;
    logic          rxd_sync;
    logic          half_done;
    logic          full_done;

    assign half_done = (cnt_q == CW'(BAUD_DIV / 2 - 1));
    assign full_done = (cnt_q == CW'(BAUD_DIV - 1));

    // Line idles high
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd_i;
            rxd_sync <= rxd_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= RX_IDLE;
            cnt_q      <= '0;
            bit_q      <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    bit_q <= '0;
                    if (!rxd_sync) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    cnt_q <= cnt_q + 1'b1;
                    // Glitch check at the middle of the start bit
                    if (half_done) begin
                        cnt_q   <= '0;
                        state_q <= rxd_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (full_done) begin
                        cnt_q <= '0;
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                default: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (full_done) begin
                        state_q <= RX_IDLE;
                        // Framing error drops the byte
                        rx_valid_o <= rxd_sync;
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && full_done) begin
            rx_data_o <= {rxd_sync, rx_data_o[7:1]};
        end
    end

endmodule

/* source/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx #(
    parameter int BAUD_DIV = 868
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              tx_start_i,
    input  soc_pkg::byte_t    tx_data_i,
    output logic              txd_o,
    output logic              tx_busy_o
);

    localparam int CW = (BAUD_DIV > 2) ? $clog2(BAUD_DIV) : 2;

    logic [9:0]    frame_q;
    logic [3:0]    bits_q;
    logic [CW-1:0] cnt_q;

    // Frame shifts in ones behind it, so the line is high when idle
    assign txd_o = frame_q[0];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frame_q   <= '1;
            bits_q    <= '0;
            cnt_q     <= '0;
            tx_busy_o <= 1'b0;
        end else if (!tx_busy_o && tx_start_i) begin
            frame_q   <= {1'b1, tx_data_i, 1'b0};
            bits_q    <= 4'd10;
            cnt_q     <= '0;
            tx_busy_o <= 1'b1;
        end else if (tx_busy_o) begin
            if (cnt_q == CW'(BAUD_DIV - 1)) begin
                cnt_q   <= '0;
                frame_q <= {1'b1, frame_q[9:1]};
                bits_q  <= bits_q - 1'b1;
                // Stop bit done
                if (bits_q == 4'd1) begin
                    tx_busy_o <= 1'b0;
                end
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

endmodule

/* verification/board_top_chk.sv */
`timescale 1ns/1ps

module board_top_chk (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   spi_sck_i,
    input  logic                   spi_ss_i,
    input  logic                   uart_txd_i,
    input  logic [7:0]             seg_sel_i,
    input  soc_pkg::bridge_state_e state_i
);

    // SPI clock idles low outside a transfer
    sck_idle_low: assert property (@(posedge clk) disable iff (reset_i)
        spi_ss_i |-> !spi_sck_i)
        else $error("spi_sck_o high while spi_ss_o is high");

    // Line held idle during reset
    txd_high_in_reset: assert property (@(posedge clk)
        reset_i ##1 reset_i |-> uart_txd_i)
        else $error("uart_txd_o low while reset is held");

    one_digit_lit: assert property (@(posedge clk) disable iff (reset_i)
        $countones(~seg_sel_i) <= 1)
        else $error("more than one digit select active");

    // Chip select only while the bridge waits for the transfer
    ss_only_in_spi_wait: assert property (@(posedge clk) disable iff (reset_i)
        !spi_ss_i |-> state_i == soc_pkg::ST_SPI_WAIT)
        else $error("spi_ss_o low outside ST_SPI_WAIT");

endmodule

bind board_top board_top_chk u_board_top_chk (
    .clk(clk), .reset_i(reset_i),
    .spi_sck_i(spi_sck_o), .spi_ss_i(spi_ss_o),
    .uart_txd_i(uart_txd_o), .seg_sel_i(seg_sel_o),
    .state_i(u_cmd_bridge.state_q)
);

/* verification/tb_board_top.sv */
`timescale 1ns/1ps

module tb_board_top;

    localparam int BAUD_DIV = 16;
    localparam int SPI_DIV  = 4;
    localparam int SCAN_DIV = 8;
    localparam int CLK_NS   = 40;

    localparam int N_LED = 8;
    localparam int N_SEG = 2;
    localparam int N_SW  = 3;
    localparam int N_SPI = 4;
    localparam int N_BAD = 3;
    localparam int N_CMDS = N_LED + N_SEG + N_SW + N_SPI + N_BAD;

    localparam longint BIT_NS = BAUD_DIV * CLK_NS;
    localparam longint SPI_NS = (2 * SPI_DIV * 8 + SPI_DIV + 2) * CLK_NS;
    // Doubled time of four UART frames and two SPI transfers per command
    localparam longint WATCHDOG_NS = 2 * N_CMDS * (4 * 10 * BIT_NS + 2 * SPI_NS);

    logic        clk;
    logic        reset_i;
    logic [7:0]  switch_i;
    logic [15:0] led_o;
    logic [7:0]  seg_sel_o;
    logic [7:0]  seg_bit_o;
    logic        spi_sck_o;
    logic        spi_ss_o;
    logic        spi_mosi_o;
    logic        spi_miso_i;
    logic        uart_rxd_i;
    logic        uart_txd_o;

    soc_pkg::byte_t exp_q[$];
    int             cmds_sent;
    int             replies_seen;
    logic [15:0]    exp_led;
    soc_pkg::byte_t exp_seg;
    soc_pkg::byte_t slave_byte;
    soc_pkg::byte_t mosi_cap;
    int             slave_bit;
    int             sck_pulses;
    logic [6:0]     font_tab [16];

    board_top #(.BAUD_DIV(BAUD_DIV), .SPI_DIV(SPI_DIV), .SCAN_DIV(SCAN_DIV)) DUT (
        .clk(clk), .reset_i(reset_i), .switch_i(switch_i), .led_o(led_o),
        .seg_sel_o(seg_sel_o), .seg_bit_o(seg_bit_o),
        .spi_sck_o(spi_sck_o), .spi_ss_o(spi_ss_o),
        .spi_mosi_o(spi_mosi_o), .spi_miso_i(spi_miso_i),
        .uart_rxd_i(uart_rxd_i), .uart_txd_o(uart_txd_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        report_failure();
    end

    task automatic report_failure();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_byte(input string name, input soc_pkg::byte_t got,
                              input soc_pkg::byte_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_led(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("mismatch led_o: got 0x%04h, expected 0x%04h", got, exp);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            report_failure();
        end
    endtask

    // Protocol reply that also tracks the LED and SEG state
    function automatic soc_pkg::byte_t reference_reply(input soc_pkg::byte_t op,
            input soc_pkg::byte_t data, input soc_pkg::byte_t sw,
            input soc_pkg::byte_t slave);
        case (op)
            soc_pkg::OP_LED_LO: begin
                exp_led[7:0] = data;
                return data;
            end
            soc_pkg::OP_LED_HI: begin
                exp_led[15:8] = data;
                return data;
            end
            soc_pkg::OP_SEG: begin
                exp_seg = data;
                return data;
            end
            soc_pkg::OP_SWITCH: return sw;
            soc_pkg::OP_SPI:    return slave;
            default:            return soc_pkg::REPLY_BAD;
        endcase
    endfunction

    task automatic tick(input int n);
        repeat (n) begin
            @(posedge clk);
            #5;
        end
    endtask

    // 8N1 host frame with LSB first
    task automatic send_byte(input soc_pkg::byte_t b);
        uart_rxd_i = 1'b0;
        tick(BAUD_DIV);
        for (int i = 0; i < 8; i++) begin
            uart_rxd_i = b[i];
            tick(BAUD_DIV);
        end
        uart_rxd_i = 1'b1;
        tick(BAUD_DIV);
    endtask

    task automatic recv_byte(output soc_pkg::byte_t b);
        @(negedge uart_txd_o);
        #(BIT_NS / 2);
        if (uart_txd_o !== 1'b0) begin
            $display("Start bit on uart_txd_o did not hold until mid-bit");
            report_failure();
        end
        for (int i = 0; i < 8; i++) begin
            #(BIT_NS);
            b[i] = uart_txd_o;
        end
        #(BIT_NS);
        if (uart_txd_o !== 1'b1) begin
            $display("Stop bit on uart_txd_o was low");
            report_failure();
        end
    endtask

    task automatic run_cmd(input soc_pkg::byte_t op, input soc_pkg::byte_t data);
        exp_q.push_back(reference_reply(op, data, switch_i, slave_byte));
        cmds_sent++;
        send_byte(op);
        send_byte(data);
        wait (replies_seen == cmds_sent);
        tick(BAUD_DIV);
    endtask

    task automatic wait_digit(input logic [7:0] sel);
        int n;
        n = 0;
        while (seg_sel_o !== sel) begin
            if (n == 4 * SCAN_DIV) begin
                $display("Digit select 0x%02h never appeared on seg_sel_o", sel);
                report_failure();
            end
            tick(1);
            n++;
        end
    endtask

    task automatic check_display();
        wait_digit(8'hFE);
        check_byte("seg_bit_o", seg_bit_o, {1'b1, ~font_tab[exp_seg[3:0]]});
        wait_digit(8'hFD);
        check_byte("seg_bit_o", seg_bit_o, {1'b1, ~font_tab[exp_seg[7:4]]});
    endtask

    // Compares every reply on uart_txd_o with the oldest expected value
    initial begin : reply_monitor
        soc_pkg::byte_t got;
        wait (reset_i === 1'b0);
        forever begin
            recv_byte(got);
            if (exp_q.size() == 0) begin
                $display("Reply 0x%02h arrived with no command pending", got);
                report_failure();
            end
            check_byte("reply", got, exp_q.pop_front());
            replies_seen++;
        end
    end

    // Mode-0 SPI slave
    always @(negedge spi_ss_o) begin
        slave_bit  = 7;
        sck_pulses = 0;
        spi_miso_i = slave_byte[7];
    end

    always @(negedge spi_sck_o) begin
        if (spi_ss_o === 1'b0 && slave_bit > 0) begin
            slave_bit  = slave_bit - 1;
            spi_miso_i = slave_byte[slave_bit];
        end
    end

    always @(posedge spi_sck_o) begin
        if (spi_ss_o === 1'b0) begin
            mosi_cap   = {mosi_cap[6:0], spi_mosi_o};
            sck_pulses = sck_pulses + 1;
        end
    end

    initial begin : stimulus
        soc_pkg::byte_t op;
        soc_pkg::byte_t data;
        reset_i    = 1'b1;
        switch_i   = 8'h00;
        spi_miso_i = 1'b0;
        uart_rxd_i = 1'b1;
        cmds_sent    = 0;
        replies_seen = 0;
        exp_led    = 16'h0000;
        exp_seg    = 8'h00;
        slave_byte = 8'h00;
        mosi_cap   = 8'h00;
        font_tab = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                     7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
        void'($urandom(20496));

        repeat (10) @(posedge clk);
        #5;
        reset_i = 1'b0;
        tick(1);
        check_bit("uart_txd_o", uart_txd_o, 1'b1);
        check_bit("spi_ss_o", spi_ss_o, 1'b1);
        check_bit("spi_sck_o", spi_sck_o, 1'b0);
        check_led(led_o, 16'h0000);

        for (int i = 0; i < N_LED; i++) begin
            op = i[0] ? soc_pkg::OP_LED_HI : soc_pkg::OP_LED_LO;
            run_cmd(op, soc_pkg::byte_t'($urandom));
            check_led(led_o, exp_led);
        end

        for (int i = 0; i < N_SEG; i++) begin
            run_cmd(soc_pkg::OP_SEG, soc_pkg::byte_t'($urandom));
            check_display();
        end

        // Switches settle well ahead of the command
        for (int i = 0; i < N_SW; i++) begin
            switch_i = soc_pkg::byte_t'($urandom);
            tick(4);
            run_cmd(soc_pkg::OP_SWITCH, soc_pkg::byte_t'($urandom));
        end

        for (int i = 0; i < N_SPI; i++) begin
            slave_byte = soc_pkg::byte_t'($urandom);
            data = soc_pkg::byte_t'($urandom);
            run_cmd(soc_pkg::OP_SPI, data);
            check_byte("spi_mosi_o", mosi_cap, data);
            check_byte("sck_pulses", soc_pkg::byte_t'(sck_pulses), 8'd8);
        end

        for (int i = 0; i < N_BAD; i++) begin
            do begin
                op = soc_pkg::byte_t'($urandom);
            end while (op inside {[8'h01:8'h05]});
            run_cmd(op, soc_pkg::byte_t'($urandom));
            check_led(led_o, exp_led);
        end

        // Room for a stray extra reply to reach the monitor
        tick(12 * BAUD_DIV);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* verilog.f */
source/soc_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/cmd_bridge.sv
source/gpio_ctrl.sv
source/spi_master.sv
source/board_top.sv
verification/board_top_chk.sv
verification/tb_board_top.sv
